/* vlog.f */
logic/aluPkg.sv
logic/opDecode.sv
logic/arithUnit.sv
logic/logicShiftUnit.sv
logic/branchUnit.sv
logic/resultStage.sv
logic/aluCore.sv
tb/aluCore_assert.sv
tb/aluTb.sv

/* run.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aluTb -f vlog.f -o ValuTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ValuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* tb/aluTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTb;

	localparam int dataWidth   = 16;
	localparam int halfPeriod  = 4; // 8 ns clock
	localparam int resetCycles = 10;
	// Arith 30, compare 6, logic 40, shifts 10, branches 96, pipeline 4 and reset 1
	localparam int numOps = 30 + 6 + 40 + 10 + 2 * 16 * 3 + 4 + 1;

	typedef logic [dataWidth-1:0] wordT;

	typedef struct packed {
		wordT          res;
		aluPkg::flagsT fl;
	} expT;

	logic          clk = 1'b0;
	logic          arstN;
	logic          inValid;
	aluPkg::aluOpU aluOp;
	wordT          aluIn1;
	wordT          aluIn2;
	wordT          pcIn;
	logic          outValid;
	wordT          aluOut;
	aluPkg::flagsT flags;

	logic [15:0]   lfsr; // Operand source
	aluPkg::flagsT modelFlags; // Expected flag register
	wordT          lastRes; // Result register contents after the last pop
	expT           expQ[$]; // Results in flight with the oldest first
	int            errCount = 0;
	int            checkCount = 0;

	aluCore #(.dataWidth(dataWidth)) u_dut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.aluOp    (aluOp),
		.aluIn1   (aluIn1),
		.aluIn2   (aluIn2),
		.pcIn     (pcIn),
		.outValid (outValid),
		.aluOut   (aluOut),
		.flags    (flags)
	);

	always #halfPeriod clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic wordT randBits(input int nBits);
		wordT w;
		w = '0;
		for (int i = 0; i < nBits; i++)
		begin
			lfsr = lfsrStep(lfsr); // One step per bit
			w = {w[dataWidth-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic expT predictAddSub(input wordT a, input wordT bb, input logic sub,
		input logic setCF, input aluPkg::flagsT fIn);
		expT e;
		int  full; // Exact signed result
		full = sub ? int'($signed(a)) - int'($signed(bb)) : int'($signed(a)) + int'($signed(bb));
		e.res = sub ? a - bb : a + bb;
		e.fl = fIn;
		if (setCF)
		begin
			e.fl.c = sub ? (a < bb) : ((int'(a) + int'(bb)) > 65535); // Borrow or carry
			e.fl.f = (full > 32767) || (full < -32768);
		end
		return e;
	endfunction

	function automatic expT predictCompare(input wordT a, input wordT bb,
		input aluPkg::flagsT fIn);
		expT e;
		e.res = a; // Rdest comes back unchanged
		e.fl = fIn;
		e.fl.l = a < bb;
		e.fl.z = a == bb;
		e.fl.n = $signed(a) < $signed(bb);
		return e;
	endfunction

	function automatic wordT predictShift(input wordT a, input int amt, input logic right,
		input logic arith);
		wordT r;
		if (!right)
			r = a << amt;
		else if (arith)
			r = $signed(a) >>> amt; // Sign bit refills the top
		else
			r = a >> amt;
		return r;
	endfunction

	function automatic logic branchTaken(input logic [3:0] cond, input aluPkg::flagsT f);
		logic t;
		case (cond)
			4'h0: t = f.z;
			4'h1: t = !f.z;
			4'h2: t = f.c;
			4'h3: t = !f.c;
			4'h4: t = !f.l && !f.z; // HI
			4'h5: t = f.l || f.z;
			4'h6: t = !f.n && !f.z; // GT
			4'h7: t = f.n || f.z;
			4'h8: t = f.f;
			4'h9: t = !f.f;
			4'hA: t = f.l;
			4'hB: t = !f.l;
			4'hC: t = f.n;
			4'hD: t = !f.n;
			4'hE: t = 1'b1; // UC
			default: t = 1'b0; // NJ
		endcase
		return t;
	endfunction

	function automatic expT predict(input logic [7:0] code, input wordT a, input wordT b,
		input wordT pc, input aluPkg::flagsT fIn);
		expT  e;
		wordT zx;
		wordT sx;
		int   shv;
		zx = {8'h00, b[7:0]}; // Zero-extended immediate
		sx = {{8{b[7]}}, b[7:0]};
		shv = int'($signed(b)); // Register shift distance
		e.res = a; // Unknown opcodes pass Rdest
		e.fl = fIn;
		casez (code)
			8'h01: e.res = a & b;
			8'h02: e.res = a | b;
			8'h03: e.res = a ^ b;
			8'h0F: e.res = ~a;
			8'h0D: e.res = b;
			8'h05: e = predictAddSub(a, b, 1'b0, 1'b1, fIn);
			8'h06: e = predictAddSub(a, b, 1'b0, 1'b0, fIn); // ADDU
			8'h09: e = predictAddSub(a, b, 1'b1, 1'b1, fIn);
			8'h0B: e = predictCompare(a, b, fIn);
			8'h80, 8'h81: e.res = predictShift(a, int'(b[3:0]), code[0], 1'b0);
			8'h82, 8'h83: e.res = predictShift(a, int'(b[3:0]), code[0], 1'b1);
			8'h84, 8'h86:
			begin
				if (shv < 0)
					e.res = predictShift(a, -shv, 1'b1, code == 8'h86);
				else
					e.res = predictShift(a, shv, 1'b0, code == 8'h86);
			end
			8'h4C: e.res = branchTaken(a[3:0], fIn) ? b : pc + 16'd1; // Jcond
			8'h1?: e.res = a & zx;
			8'h2?: e.res = a | zx;
			8'h3?: e.res = a ^ zx;
			8'h5?: e = predictAddSub(a, sx, 1'b0, 1'b1, fIn);
			8'h6?: e = predictAddSub(a, zx, 1'b0, 1'b0, fIn);
			8'h9?: e = predictAddSub(a, sx, 1'b1, 1'b1, fIn);
			8'hB?: e = predictCompare(a, sx, fIn);
			8'hC?: e.res = branchTaken(a[3:0], fIn) ? pc + sx : pc + 16'd1; // Bcond
			8'hD?: e.res = zx;
			8'hF?: e.res = {b[7:0], 8'h00};
			default: ;
		endcase
		return e;
	endfunction

	task automatic checkData(input wordT expVal, input wordT actVal);
		checkCount++;
		if (actVal !== expVal)
		begin
			errCount++;
			$display("Error aluOut: expected %h, got %h at %0t", expVal, actVal, $time);
		end
	endtask

	task automatic checkFlags(input aluPkg::flagsT expVal, input aluPkg::flagsT actVal);
		checkCount++;
		if (actVal !== expVal)
		begin
			errCount++;
			$display("Error flags: expected %h, got %h at %0t", expVal, actVal, $time);
		end
	endtask

	// Called on a falling edge when outputs are settled
	task automatic collectResult();
		expT e;
		if (outValid)
		begin
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("outValid was high with no operation outstanding at %0t", $time);
			end
			else
			begin
				e = expQ.pop_front();
				lastRes = e.res;
				checkData(e.res, aluOut);
				checkFlags(e.fl, flags);
			end
		end
	endtask

	task automatic issueOp(input logic [7:0] code, input wordT a, input wordT b, input wordT pc);
		expT e;
		@(negedge clk);
		collectResult();
		e = predict(code, a, b, pc, modelFlags);
		modelFlags = e.fl; // Next op sees these flags
		expQ.push_back(e);
		aluOp = code;
		aluIn1 = a;
		aluIn2 = b;
		pcIn = pc;
		inValid = 1'b1;
	endtask

	task automatic drainResults();
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		collectResult();
		inValid = 1'b0;
		aluOp = aluPkg::OP_CMP; // Idle inputs that would move aluOut and Z if captured
		aluIn1 = ~lastRes;
		aluIn2 = ~lastRes ^ wordT'(modelFlags.z);
		while (expQ.size() != 0 && waitCycles < 4)
		begin
			@(negedge clk);
			collectResult();
			waitCycles++;
		end
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("outValid never came for %0d pending results", expQ.size());
			expQ.delete();
		end
	endtask

	task automatic applyReset();
		arstN = 1'b0;
		inValid = 1'b0;
		expQ.delete();
		repeat (resetCycles) @(negedge clk);
		arstN = 1'b1;
		modelFlags = '0;
		checkData('0, aluOut); // Registers come out of reset cleared
		checkFlags('0, flags);
		if (outValid)
		begin
			errCount++;
			$display("outValid was high right after reset");
		end
	endtask

	task automatic arithCases();
		wordT a;
		wordT b;
		for (int i = 0; i < 4; i++)
		begin
			a = randBits(16);
			b = randBits(16);
			issueOp(8'h05, a, b, '0);
			issueOp({4'h5, 4'(i)}, a, b, '0); // ADDI
			issueOp(8'h06, a, b, '0); // ADDU leaves flags
			issueOp({4'h6, 4'(i)}, a, b, '0);
			issueOp(8'h09, a, b, '0);
			issueOp({4'h9, 4'(i)}, a, b, '0); // SUBI
		end
		issueOp(8'h05, 16'h7FFF, 16'h0001, '0); // Signed overflow
		issueOp(8'h09, 16'h8000, 16'h0001, '0);
		issueOp(8'h09, 16'h0000, 16'h0001, '0); // Borrow
		issueOp(8'h50, 16'h7FFF, 16'hAA01, '0);
		issueOp(8'h90, 16'h0000, 16'h5501, '0);
		issueOp(8'h05, 16'hFFFF, 16'h0001, '0); // Carry out without overflow
		drainResults();
	endtask

	task automatic compareCases();
		issueOp(8'h0B, 16'h1234, 16'h1234, '0); // Equal
		issueOp(8'h0B, 16'h0001, 16'h8000, '0); // Unsigned below only
		issueOp(8'h0B, 16'h8000, 16'h0001, '0); // Signed below only
		issueOp(8'hB0, 16'h0005, 16'hC305, '0);
		issueOp(8'hB1, 16'hFFF0, 16'h007F, '0);
		issueOp(8'hB2, 16'h0003, 16'h00FF, '0); // Immediate sign-extends to FFFF
		drainResults();
	endtask

	task automatic logicCases();
		wordT a;
		wordT b;
		for (int i = 0; i < 4; i++)
		begin
			a = randBits(16);
			b = randBits(16); // Upper byte must be ignored by immediates
			issueOp(8'h01, a, b, '0);
			issueOp(8'h02, a, b, '0);
			issueOp(8'h03, a, b, '0);
			issueOp(8'h0F, a, b, '0);
			issueOp(8'h0D, a, b, '0);
			issueOp({4'h1, 4'(i)}, a, b, '0);
			issueOp({4'h2, 4'(i)}, a, b, '0);
			issueOp({4'h3, 4'(i)}, a, b, '0);
			issueOp({4'hD, 4'(i)}, a, b, '0);
			issueOp({4'hF, 4'(i)}, a, b, '0); // LUI
		end
		drainResults();
	endtask

	task automatic shiftCases();
		wordT a;
		a = randBits(16);
		issueOp(8'h80, a, 16'h0013, '0); // Only the low 4 bits count
		issueOp(8'h81, a, 16'h0005, '0);
		issueOp(8'h82, 16'h8000, 16'h0004, '0);
		issueOp(8'h83, 16'h8000, 16'h0004, '0); // Sign replication
		issueOp(8'h83, a, randBits(4), '0);
		issueOp(8'h84, a, 16'h0002, '0);
		issueOp(8'h84, 16'h8000, 16'hFFF1, '0); // Right by 15 with zero fill
		issueOp(8'h86, a, 16'h0001, '0);
		issueOp(8'h86, 16'h8000, 16'hFFF1, '0);
		issueOp(8'h86, a, 16'hFFFD, '0);
		drainResults();
	endtask

	// SUB sets C and F and CMP sets L, Z and N right before each branch
	task automatic branchCases();
		wordT x;
		wordT y;
		logic useJump;
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int cond = 0; cond < 16; cond++)
			begin
				x = randBits(16);
				y = randBits(16);
				useJump = pass[0] ^ cond[0]; // Each condition gets both forms
				issueOp(8'h09, x, y, '0);
				if (pass == 0)
					issueOp(8'h0B, x, x, '0);
				else
					issueOp(8'h0B, y, x, '0);
				issueOp(useJump ? 8'h4C : {4'hC, 4'(cond)}, {y[15:4], 4'(cond)},
					randBits(16), randBits(16));
			end
		end
		drainResults();
	endtask

	task automatic pipelineCases();
		logic [7:0] codes[4];
		codes = '{8'h05, 8'h03, 8'h09, 8'hD7};
		for (int i = 0; i < 4; i++)
		begin
			issueOp(codes[i], randBits(16), randBits(16), '0);
			if (expQ.size() != 1)
			begin
				errCount++;
				$display("Results did not arrive one cycle apart on back-to-back issue");
			end
		end
		drainResults();
		@(negedge clk);
		if (outValid)
		begin
			errCount++;
			$display("outValid stayed high on an idle cycle");
		end
		checkData(lastRes, aluOut); // Registers hold across the idle cycle
		checkFlags(modelFlags, flags);
	endtask

	initial
	begin
		arstN = 1'b0;
		inValid = 1'b0;
		aluOp = '0;
		aluIn1 = '0;
		aluIn2 = '0;
		pcIn = '0;
		lfsr = 16'd89;
		modelFlags = '0;
		lastRes = '0;
		applyReset();
		arithCases();
		compareCases();
		logicCases(); // Runs on non-zero flags, which must survive
		shiftCases();
		branchCases();
		pipelineCases();
		issueOp(8'h0D, randBits(16), randBits(16), '0); // Reset lands on a live result
		@(negedge clk);
		collectResult();
		applyReset();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		repeat (numOps * 4 + 40) @(posedge clk);
		$display("Watchdog expired before all operations completed");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/aluCore_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module aluCoreAssert (
	input wire                clk,
	input wire                arstN,
	input wire                inValid,
	input wire                outValid,
	input wire aluPkg::flagsT flags
);

	resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
		else $error("outValid high while reset is asserted");

	// One cycle of latency, no more and no less
	validFollows: assert property (@(posedge clk) disable iff (!arstN) inValid |=> outValid)
		else $error("outValid missing one cycle after inValid");

	idleFollows: assert property (@(posedge clk) disable iff (!arstN) !inValid |=> !outValid)
		else $error("outValid high one cycle after an idle cycle");

	flagsHold: assert property (@(posedge clk) disable iff (!arstN) !inValid |=> $stable(flags))
		else $error("flags changed after a cycle with no operation");

endmodule

bind aluCore aluCoreAssert u_aluCoreAssert (
	.clk      (clk),
	.arstN    (arstN),
	.inValid  (inValid),
	.outValid (outValid),
	.flags    (flags)
);

`default_nettype wire

/* logic/aluCore.sv */
`timescale 1ns/1ns
`default_nettype none

module aluCore #(
	parameter int dataWidth = 16
) (
	input  wire                    clk,
	input  wire                    arstN,
	input  wire                    inValid,
	input  wire aluPkg::aluOpU     aluOp,
	input  wire [dataWidth-1:0]    aluIn1, // Rdest, or the condition for branches
	input  wire [dataWidth-1:0]    aluIn2, // Rsrc or immediate
	input  wire [dataWidth-1:0]    pcIn,
	output logic                   outValid,
	output logic [dataWidth-1:0]   aluOut,
	output aluPkg::flagsT          flags
);

	aluPkg::aluCtrlT      ctrl;
	logic [dataWidth-1:0] opB; // Shaped operand B
	logic [dataWidth-1:0] arithRes;
	aluPkg::flagsT        newFlags;
	logic [dataWidth-1:0] lsRes;
	logic [dataWidth-1:0] pcNext;

	opDecode #(.dataWidth(dataWidth)) u_opDecode (
		.aluOp  (aluOp),
		.aluIn2 (aluIn2),
		.ctrl   (ctrl),
		.opB    (opB)
	);

	arithUnit #(.dataWidth(dataWidth)) u_arithUnit (
		.ctrl     (ctrl),
		.aluIn1   (aluIn1),
		.opB      (opB),
		.oldFlags (flags), // Stored flags feed back for the merge
		.arithRes (arithRes),
		.newFlags (newFlags)
	);

	logicShiftUnit #(.dataWidth(dataWidth)) u_logicShiftUnit (
		.ctrl   (ctrl),
		.aluIn1 (aluIn1),
		.opB    (opB),
		.lsRes  (lsRes)
	);

	branchUnit #(.dataWidth(dataWidth)) u_branchUnit (
		.ctrl   (ctrl),
		.cond   (aluPkg::condT'(aluIn1[aluPkg::COND_W-1:0])),
		.aluIn2 (aluIn2),
		.pcIn   (pcIn),
		.flags  (flags),
		.pcNext (pcNext)
	);

	resultStage #(.dataWidth(dataWidth)) u_resultStage (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.ctrl     (ctrl),
		.arithRes (arithRes),
		.lsRes    (lsRes),
		.pcNext   (pcNext),
		.aluIn1   (aluIn1),
		.newFlags (newFlags),
		.outValid (outValid),
		.aluOut   (aluOut),
		.flags    (flags)
	);

endmodule

`default_nettype wire

/* logic/resultStage.sv */
`timescale 1ns/1ns
`default_nettype none

module resultStage #(
	parameter int dataWidth = 16
) (
	input  wire                    clk,
	input  wire                    arstN,
	input  wire                    inValid,
	input  wire aluPkg::aluCtrlT   ctrl,
	input  wire [dataWidth-1:0]    arithRes,
	input  wire [dataWidth-1:0]    lsRes,
	input  wire [dataWidth-1:0]    pcNext,
	input  wire [dataWidth-1:0]    aluIn1,
	input  wire aluPkg::flagsT     newFlags,
	output logic                   outValid,
	output logic [dataWidth-1:0]   aluOut,
	output aluPkg::flagsT          flags
);

	logic [dataWidth-1:0] resSel;

	always_comb
	begin
		case (ctrl.opClass)
			aluPkg::CLS_ARITH:  resSel = arithRes;
			aluPkg::CLS_LOGIC,
			aluPkg::CLS_SHIFT:  resSel = lsRes;
			aluPkg::CLS_BRANCH: resSel = pcNext;
			default:            resSel = aluIn1; // Unknown op passes Rdest
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			aluOut <= '0;
			flags <= '0;
		end
		else
		begin
			outValid <= inValid; // Drops on idle cycles
			if (inValid)
			begin
				aluOut <= resSel;
				flags <= newFlags; // Same edge as the result
			end
		end
	end

endmodule

`default_nettype wire

/* logic/branchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module branchUnit #(
	parameter int dataWidth = 16
) (
	input  wire aluPkg::aluCtrlT   ctrl,
	input  wire aluPkg::condT      cond,
	input  wire [dataWidth-1:0]    aluIn2,
	input  wire [dataWidth-1:0]    pcIn,
	input  wire aluPkg::flagsT     flags,
	output logic [dataWidth-1:0]   pcNext
);

	logic                 taken;
	logic [dataWidth-1:0] disp; // Sign-extended branch offset
	logic [dataWidth-1:0] target;

	// Evaluated on the stored flags of the previous op
	always_comb
	begin
		case (cond)
			aluPkg::EQ: taken = flags.z;
			aluPkg::NE: taken = ~flags.z;
			aluPkg::CS: taken = flags.c;
			aluPkg::CC: taken = ~flags.c;
			aluPkg::HI: taken = ~(flags.l | flags.z); // Unsigned above
			aluPkg::LS: taken = flags.l | flags.z;
			aluPkg::LO: taken = flags.l;
			aluPkg::HS: taken = ~flags.l;
			aluPkg::GT: taken = ~(flags.n | flags.z); // Signed above
			aluPkg::LE: taken = flags.n | flags.z;
			aluPkg::LT: taken = flags.n;
			aluPkg::GE: taken = ~flags.n;
			aluPkg::FS: taken = flags.f;
			aluPkg::FC: taken = ~flags.f;
			aluPkg::UC: taken = 1'b1;
			default:    taken = 1'b0; // NJ
		endcase
	end

	assign disp = {{(dataWidth-aluPkg::IMM_W){aluIn2[aluPkg::IMM_W-1]}},
		aluIn2[aluPkg::IMM_W-1:0]};
	assign target = ctrl.isJump ? aluIn2 : pcIn + disp; // Jcond is absolute

	assign pcNext = taken ? target : pcIn + dataWidth'(1);

endmodule

`default_nettype wire

/* logic/logicShiftUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module logicShiftUnit #(
	parameter int dataWidth = 16
) (
	input  wire aluPkg::aluCtrlT   ctrl,
	input  wire [dataWidth-1:0]    aluIn1,
	input  wire [dataWidth-1:0]    opB,
	output logic [dataWidth-1:0]   lsRes
);

	logic [dataWidth-1:0] logicRes;
	logic [dataWidth-1:0] shAmt; // Shift distance, always a magnitude
	logic                 goRight;
	logic [dataWidth-1:0] srlRes;
	logic [dataWidth-1:0] sraRes;
	logic [dataWidth-1:0] sllRes;
	logic [dataWidth-1:0] shiftRes;

	always_comb
	begin
		case (ctrl.logicFn)
			aluPkg::LF_AND: logicRes = aluIn1 & opB;
			aluPkg::LF_OR:  logicRes = aluIn1 | opB;
			aluPkg::LF_XOR: logicRes = aluIn1 ^ opB; // NOT arrives with opB all ones
			default:        logicRes = opB; // Moves and LUI
		endcase
	end

	always_comb
	begin
		if (ctrl.shiftFromImm)
		begin
			goRight = ctrl.shiftRight;
			shAmt = {{(dataWidth-4){1'b0}}, opB[3:0]}; // Low 4 bits only
		end
		else
		begin
			goRight = opB[dataWidth-1]; // Negative Rsrc shifts right
			shAmt = opB[dataWidth-1] ? -opB : opB;
		end
	end

	assign srlRes = aluIn1 >> shAmt;
	assign sraRes = $signed(aluIn1) >>> shAmt; // Sign bit fills from the left
	assign sllRes = aluIn1 << shAmt;

	always_comb
	begin
		if (!goRight)
			shiftRes = sllRes;
		else if (ctrl.shiftArith)
			shiftRes = sraRes;
		else
			shiftRes = srlRes;
	end

	assign lsRes = (ctrl.opClass == aluPkg::CLS_SHIFT) ? shiftRes : logicRes;

endmodule

`default_nettype wire

/* logic/arithUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module arithUnit #(
	parameter int dataWidth = 16
) (
	input  wire aluPkg::aluCtrlT   ctrl,
	input  wire [dataWidth-1:0]    aluIn1,
	input  wire [dataWidth-1:0]    opB,
	input  wire aluPkg::flagsT     oldFlags,
	output logic [dataWidth-1:0]   arithRes,
	output aluPkg::flagsT          newFlags
);

	logic [dataWidth-1:0] bOper; // opB, inverted for subtract
	logic [dataWidth:0]   sum; // Top bit is the carry out
	logic                 carryOut;
	logic                 overflow;
	logic                 ltUnsigned;
	logic                 ltSigned;
	logic                 isEqual;

	assign bOper = ctrl.isSub ? ~opB : opB;
	assign sum = {1'b0, aluIn1} + {1'b0, bOper} + {{dataWidth{1'b0}}, ctrl.isSub}; // Two's complement
	assign carryOut = sum[dataWidth];

	// Operands agree in sign but the result does not
	assign overflow = (aluIn1[dataWidth-1] == bOper[dataWidth-1]) &&
		(sum[dataWidth-1] != aluIn1[dataWidth-1]);

	// Compare relations fall out of the subtraction
	assign ltUnsigned = ~carryOut; // No carry means a borrow
	assign ltSigned = sum[dataWidth-1] ^ overflow;
	assign isEqual = sum[dataWidth-1:0] == '0;

	assign arithRes = ctrl.isCmp ? aluIn1 : sum[dataWidth-1:0]; // CMP returns Rdest

	always_comb
	begin
		newFlags = oldFlags; // Keep flags the op does not own
		if (ctrl.setsCF)
		begin
			newFlags.c = ctrl.isSub ? ltUnsigned : carryOut; // Borrow on subtract
			newFlags.f = overflow;
		end
		if (ctrl.setsLNZ)
		begin
			newFlags.l = ltUnsigned;
			newFlags.z = isEqual;
			newFlags.n = ltSigned;
		end
	end

endmodule

`default_nettype wire

/* logic/opDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module opDecode #(
	parameter int dataWidth = 16
) (
	input  wire aluPkg::aluOpU     aluOp,
	input  wire [dataWidth-1:0]    aluIn2,
	output aluPkg::aluCtrlT        ctrl,
	output logic [dataWidth-1:0]   opB
);

	logic [dataWidth-1:0] immS; // Sign-extended immediate
	logic [dataWidth-1:0] immZ; // Zero-extended immediate
	logic [dataWidth-1:0] immUp; // Immediate in the top byte for LUI

	assign immS  = {{(dataWidth-aluPkg::IMM_W){aluIn2[aluPkg::IMM_W-1]}},
		aluIn2[aluPkg::IMM_W-1:0]};
	assign immZ  = {{(dataWidth-aluPkg::IMM_W){1'b0}}, aluIn2[aluPkg::IMM_W-1:0]};
	assign immUp = {aluIn2[aluPkg::IMM_W-1:0], {(dataWidth-aluPkg::IMM_W){1'b0}}};

	always_comb
	begin
		ctrl = '0; // Unknown opcodes fall out as CLS_NONE, no flag writes
		ctrl.opClass = aluPkg::CLS_NONE;
		opB = aluIn2; // Register forms use Rsrc as is
		case (aluOp.regForm.opHi)
			aluPkg::HI_REG:
			begin
				case (aluOp.regForm)
					aluPkg::OP_AND:  ctrl.opClass = aluPkg::CLS_LOGIC;
					aluPkg::OP_OR:
					begin
						ctrl.opClass = aluPkg::CLS_LOGIC;
						ctrl.logicFn = aluPkg::LF_OR;
					end
					aluPkg::OP_XOR:
					begin
						ctrl.opClass = aluPkg::CLS_LOGIC;
						ctrl.logicFn = aluPkg::LF_XOR;
					end
					aluPkg::OP_NOT:
					begin
						ctrl.opClass = aluPkg::CLS_LOGIC;
						ctrl.logicFn = aluPkg::LF_XOR;
						opB = '1; // Invert by XOR with ones
					end
					aluPkg::OP_MOV:
					begin
						ctrl.opClass = aluPkg::CLS_LOGIC;
						ctrl.logicFn = aluPkg::LF_MOVE;
					end
					aluPkg::OP_ADD:
					begin
						ctrl.opClass = aluPkg::CLS_ARITH;
						ctrl.setsCF = 1'b1;
					end
					aluPkg::OP_ADDU: ctrl.opClass = aluPkg::CLS_ARITH; // Flags untouched
					aluPkg::OP_SUB:
					begin
						ctrl.opClass = aluPkg::CLS_ARITH;
						ctrl.isSub = 1'b1;
						ctrl.setsCF = 1'b1;
					end
					aluPkg::OP_CMP:
					begin
						ctrl.opClass = aluPkg::CLS_ARITH;
						ctrl.isSub = 1'b1;
						ctrl.isCmp = 1'b1;
						ctrl.setsLNZ = 1'b1;
					end
					default: ctrl.opClass = aluPkg::CLS_NONE;
				endcase
			end
			aluPkg::HI_ANDI:
			begin
				ctrl.opClass = aluPkg::CLS_LOGIC;
				opB = immZ;
			end
			aluPkg::HI_ORI:
			begin
				ctrl.opClass = aluPkg::CLS_LOGIC;
				ctrl.logicFn = aluPkg::LF_OR;
				opB = immZ;
			end
			aluPkg::HI_XORI:
			begin
				ctrl.opClass = aluPkg::CLS_LOGIC;
				ctrl.logicFn = aluPkg::LF_XOR;
				opB = immZ;
			end
			aluPkg::HI_MOVI:
			begin
				ctrl.opClass = aluPkg::CLS_LOGIC;
				ctrl.logicFn = aluPkg::LF_MOVE;
				opB = immZ;
			end
			aluPkg::HI_LUI:
			begin
				ctrl.opClass = aluPkg::CLS_LOGIC;
				ctrl.logicFn = aluPkg::LF_MOVE;
				opB = immUp; // Low byte lands in the upper byte
			end
			aluPkg::HI_ADDI:
			begin
				ctrl.opClass = aluPkg::CLS_ARITH;
				ctrl.setsCF = 1'b1;
				opB = immS;
			end
			aluPkg::HI_ADDUI:
			begin
				ctrl.opClass = aluPkg::CLS_ARITH;
				opB = immZ;
			end
			aluPkg::HI_SUBI:
			begin
				ctrl.opClass = aluPkg::CLS_ARITH;
				ctrl.isSub = 1'b1;
				ctrl.setsCF = 1'b1;
				opB = immS;
			end
			aluPkg::HI_CMPI:
			begin
				ctrl.opClass = aluPkg::CLS_ARITH;
				ctrl.isSub = 1'b1;
				ctrl.isCmp = 1'b1;
				ctrl.setsLNZ = 1'b1;
				opB = immS;
			end
			aluPkg::HI_SHIFT:
			begin
				if (aluOp.shiftImm.shiftKind == aluPkg::OP_LSHI[3:1] ||
					aluOp.shiftImm.shiftKind == aluPkg::OP_ASHUI[3:1])
				begin
					ctrl.opClass = aluPkg::CLS_SHIFT;
					ctrl.shiftFromImm = 1'b1;
					ctrl.shiftRight = aluOp.shiftImm.rightDir;
					ctrl.shiftArith = aluOp.shiftImm.shiftKind == aluPkg::OP_ASHUI[3:1];
				end
				else if (aluOp.regForm == aluPkg::OP_LSH || aluOp.regForm == aluPkg::OP_ASHU)
				begin
					ctrl.opClass = aluPkg::CLS_SHIFT; // Direction from the sign of Rsrc
					ctrl.shiftArith = aluOp.regForm == aluPkg::OP_ASHU;
				end
			end
			aluPkg::HI_BCOND: ctrl.opClass = aluPkg::CLS_BRANCH; // PC-relative
			aluPkg::HI_JUMP:
			begin
				if (aluOp.regForm == aluPkg::OP_JCOND)
				begin
					ctrl.opClass = aluPkg::CLS_BRANCH;
					ctrl.isJump = 1'b1;
				end
			end
			default: ctrl.opClass = aluPkg::CLS_NONE;
		endcase
	end

endmodule

`default_nettype wire

/* logic/aluPkg.sv */
`default_nettype none

package aluPkg;

	localparam int IMM_W  = 8; // Immediate field in the low byte of aluIn2
	localparam int COND_W = 4; // Condition field in the low bits of aluIn1

	// Full register-form opcodes
	localparam logic [7:0] OP_AND   = 8'h01;
	localparam logic [7:0] OP_OR    = 8'h02;
	localparam logic [7:0] OP_XOR   = 8'h03;
	localparam logic [7:0] OP_ADD   = 8'h05;
	localparam logic [7:0] OP_ADDU  = 8'h06;
	localparam logic [7:0] OP_SUB   = 8'h09;
	localparam logic [7:0] OP_CMP   = 8'h0B;
	localparam logic [7:0] OP_MOV   = 8'h0D;
	localparam logic [7:0] OP_NOT   = 8'h0F;
	localparam logic [7:0] OP_LSHI  = 8'h80; // Low bit picks direction
	localparam logic [7:0] OP_ASHUI = 8'h82; // Low bit picks direction
	localparam logic [7:0] OP_LSH   = 8'h84;
	localparam logic [7:0] OP_ASHU  = 8'h86;
	localparam logic [7:0] OP_JCOND = 8'h4C;

	// Upper nibble classes
	localparam logic [3:0] HI_REG   = 4'h0; // Register forms, opExt decodes
	localparam logic [3:0] HI_ANDI  = 4'h1;
	localparam logic [3:0] HI_ORI   = 4'h2;
	localparam logic [3:0] HI_XORI  = 4'h3;
	localparam logic [3:0] HI_JUMP  = 4'h4;
	localparam logic [3:0] HI_ADDI  = 4'h5;
	localparam logic [3:0] HI_ADDUI = 4'h6;
	localparam logic [3:0] HI_SHIFT = 4'h8;
	localparam logic [3:0] HI_SUBI  = 4'h9;
	localparam logic [3:0] HI_CMPI  = 4'hB;
	localparam logic [3:0] HI_BCOND = 4'hC;
	localparam logic [3:0] HI_MOVI  = 4'hD;
	localparam logic [3:0] HI_LUI   = 4'hF;

	// Logic unit functions
	localparam logic [1:0] LF_AND  = 2'd0;
	localparam logic [1:0] LF_OR   = 2'd1;
	localparam logic [1:0] LF_XOR  = 2'd2; // Also NOT, against an all-ones mask
	localparam logic [1:0] LF_MOVE = 2'd3; // Passes opB, MOV/MOVI/LUI

	typedef enum logic [COND_W-1:0] {
		EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3,
		HI = 4'h4, LS = 4'h5, GT = 4'h6, LE = 4'h7,
		FS = 4'h8, FC = 4'h9, LO = 4'hA, HS = 4'hB,
		LT = 4'hC, GE = 4'hD, UC = 4'hE, NJ = 4'hF
	} condT;

	typedef enum logic [2:0] {
		CLS_NONE, CLS_ARITH, CLS_LOGIC, CLS_SHIFT, CLS_BRANCH
	} opClassT;

	typedef struct packed {
		logic [3:0] opHi; // Operation class
		logic [3:0] opExt; // Register-form extension
	} regFormT;

	typedef struct packed {
		logic [3:0] opHi;
		logic [2:0] shiftKind; // LSHI or ASHUI
		logic       rightDir; // Set for a right shift
	} shiftImmT;

	typedef union packed {
		regFormT  regForm;
		shiftImmT shiftImm;
	} aluOpU;

	typedef struct packed {
		opClassT    opClass;
		logic       isSub;
		logic       isCmp;
		logic       isJump; // Jcond, absolute target
		logic       shiftArith;
		logic [1:0] logicFn;
		logic       shiftRight; // Immediate shift direction
		logic       shiftFromImm;
		logic       setsCF;
		logic       setsLNZ;
	} aluCtrlT;

	typedef struct packed {
		logic c; // Carry or borrow
		logic f; // Signed overflow
		logic l; // Unsigned less
		logic z; // Equal
		logic n; // Signed less
	} flagsT;

endpackage

`default_nettype wire
